//--- bench/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_unit_tb
    import csr_pkg::*;
();

    localparam int num_requests = 280;      // upper bound on request cycles

    logic      clk;
    logic      rst_n;
    csr_op_t   op;
    csr_addr_t addr;
    u32_t      wr_data, wr_mask, rd_data;
    logic      excp_valid, badv_we, ertn, tlb_we, redirect_valid;
    ecode_t    excp_ecode;
    esubcode_t excp_esubcode;
    u32_t      excp_pc, excp_badv, redirect_pc;
    u32_t      tlb_tlbidx, tlb_tlbehi, tlb_tlbelo0, tlb_tlbelo1, tlb_asid;

    u32_t      shadow [0:16383];            // expected state by csr number
    u32_t      exp_rd, exp_mask, exp_pc;
    logic      exp_redirect;
    csr_addr_t addr_list [0:23] = '{
        `CSR_CRMD, `CSR_PRMD, `CSR_EUEN, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA, `CSR_BADV,
        `CSR_EENTRY, `CSR_TLBIDX, `CSR_TLBEHI, `CSR_TLBELO0, `CSR_TLBELO1, `CSR_ASID,
        `CSR_PGDL, `CSR_PGDH, `CSR_PGD, `CSR_CPUID, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2,
        `CSR_SAVE3, `CSR_TLBRENTRY, `CSR_DMW0, `CSR_DMW1
    };

    csr_unit i_dut (.*);

    always #2 clk = ~clk;

    // architectural writable fields per register
    function automatic u32_t write_mask(csr_addr_t a);
        case (a)
            `CSR_CRMD:   return 32'h0000_01ff;   // plv ie da pg datf datm
            `CSR_PRMD:   return 32'h0000_0007;
            `CSR_EUEN:   return 32'h0000_0001;
            `CSR_ECFG:   return 32'h0000_1fff;   // lie
            `CSR_ESTAT:  return 32'h0000_0003;   // software interrupts
            `CSR_ERA, `CSR_BADV, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                return 32'hffff_ffff;
            `CSR_EENTRY, `CSR_TLBRENTRY: return 32'hffff_ffc0;
            `CSR_TLBIDX: return 32'hbf00_0000 | ((32'd1 << `TLB_IDX_WID) - 1);  // ne ps index
            `CSR_TLBEHI: return 32'hffff_e000;   // vppn
            `CSR_TLBELO0, `CSR_TLBELO1: return ((32'd1 << (`PALEN - 4)) - 1) & ~32'h80;
            `CSR_ASID:   return (32'd1 << `ASID_WID) - 1;
            `CSR_PGDL, `CSR_PGDH: return 32'hffff_f000;
            `CSR_DMW0, `CSR_DMW1: return 32'hee00_0039;   // plv0 plv3 mat pseg vseg
            default:     return 32'h0;
        endcase
    endfunction

    function automatic u32_t read_ref(csr_addr_t a);
        case (a)
            `CSR_PGD:   return shadow[`CSR_BADV][31] ? shadow[`CSR_PGDH] : shadow[`CSR_PGDL];
            `CSR_ASID:  return shadow[`CSR_ASID] | (`ASID_WID << 16);
            `CSR_CPUID: return 32'h0;
            default:    return shadow[a];
        endcase
    endfunction

    task automatic check_value(string what, u32_t got, u32_t exp);
        if (got !== exp) begin
            $display("FAIL @%0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic clear_inputs();
        op = `OP_NONE;
        addr = '0;
        wr_data = '0;
        wr_mask = '0;
        excp_valid = 1'b0;
        excp_ecode = '0;
        excp_esubcode = '0;
        excp_pc = '0;
        badv_we = 1'b0;
        excp_badv = '0;
        ertn = 1'b0;
        tlb_we = 1'b0;
        tlb_tlbidx = '0;
        tlb_tlbehi = '0;
        tlb_tlbelo0 = '0;
        tlb_tlbelo1 = '0;
        tlb_asid = '0;
        exp_rd = '0;
        exp_mask = '0;
        exp_pc = '0;
        exp_redirect = 1'b0;
    endtask

    task automatic start_cycle();
        @(posedge clk);
        #1;
        clear_inputs();
    endtask

    // apply is low when a stronger writer owns the cycle
    task automatic set_inst(csr_op_t o, csr_addr_t a, u32_t d, u32_t m, u32_t chk,
                            logic apply);
        u32_t wm;
        u32_t nv;
        wm = write_mask(a);
        op = o;
        addr = a;
        wr_data = d;
        wr_mask = m;
        exp_rd = read_ref(a);
        exp_mask = chk;
        nv = (o == `OP_XCHG) ? ((d & m) | (exp_rd & ~m)) : d;
        if (apply && (o == `OP_WR || o == `OP_XCHG)) begin
            shadow[a] = (shadow[a] & ~wm) | (nv & wm);
        end
    endtask

    task automatic csr_request(csr_op_t o, csr_addr_t a, u32_t d, u32_t m, u32_t chk);
        start_cycle();
        set_inst(o, a, d, m, chk, 1'b1);
    endtask

    // trap entry saves the context and drops to plv 0
    task automatic raise_excp(ecode_t ec, esubcode_t sub, u32_t pc, logic bw, u32_t bad);
        logic refill;
        refill = (ec == `ECODE_TLBR);
        excp_valid = 1'b1;
        excp_ecode = ec;
        excp_esubcode = sub;
        excp_pc = pc;
        badv_we = bw;
        excp_badv = bad;
        exp_redirect = 1'b1;
        exp_pc = refill ? shadow[`CSR_TLBRENTRY] : shadow[`CSR_EENTRY];
        shadow[`CSR_PRMD] = {29'b0, shadow[`CSR_CRMD][2:0]};
        shadow[`CSR_CRMD][4:0] = refill ? 5'b01000 : 5'b10000;  // {pg, da, ie, plv}
        shadow[`CSR_ESTAT][30:16] = {sub, ec};
        shadow[`CSR_ERA] = pc;
        if (bw) begin
            shadow[`CSR_BADV] = bad;
        end
    endtask

    task automatic take_ertn();
        ertn = 1'b1;
        exp_redirect = 1'b1;
        exp_pc = shadow[`CSR_ERA];
        shadow[`CSR_CRMD][2:0] = shadow[`CSR_PRMD][2:0];
    endtask

    task automatic load_tlb(u32_t idx, u32_t ehi, u32_t lo0, u32_t lo1, u32_t asid_v);
        tlb_we = 1'b1;
        tlb_tlbidx = idx;
        tlb_tlbehi = ehi;
        tlb_tlbelo0 = lo0;
        tlb_tlbelo1 = lo1;
        tlb_asid = asid_v;
        shadow[`CSR_TLBIDX] = idx & write_mask(`CSR_TLBIDX);
        shadow[`CSR_TLBEHI] = ehi & write_mask(`CSR_TLBEHI);
        shadow[`CSR_TLBELO0] = lo0 & write_mask(`CSR_TLBELO0);
        shadow[`CSR_TLBELO1] = lo1 & write_mask(`CSR_TLBELO1);
        shadow[`CSR_ASID] = asid_v & write_mask(`CSR_ASID);
    endtask

    task automatic check_all();
        foreach (addr_list[i]) csr_request(`OP_RD, addr_list[i], 0, 0, '1);
    endtask

    // sample one ns before the next edge
    always @(posedge clk) begin
        #3;
        if (op == `OP_NONE) begin
            check_value("rd_data without a request", rd_data, 32'h0);
        end else if (exp_mask != '0) begin
            check_value($sformatf("rd_data of csr %h", addr), rd_data & exp_mask,
                        exp_rd & exp_mask);
        end
        check_value("redirect_valid", {31'b0, redirect_valid}, {31'b0, exp_redirect});
        if (exp_redirect) begin
            check_value("redirect_pc", redirect_pc, exp_pc);
        end
    end

    initial begin
        void'($urandom(70482));
        clk = 1'b0;
        rst_n = 1'b0;
        clear_inputs();
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        shadow[`CSR_CRMD] = 32'h0000_0008;     // da after reset
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        csr_request(`OP_RD, `CSR_CRMD, 0, 0, '1);
        csr_request(`OP_RD, `CSR_CPUID, 0, 0, '1);
        csr_request(`OP_RD, `CSR_ASID, 0, 0, 32'h00ff_0000);   // width field only
        csr_request(`OP_RD, `CSR_ECFG, 0, 0, '1);
        csr_request(`OP_RD, `CSR_DMW0, 0, 0, 32'h0000_0009);

        // first pass fills registers without a reset value
        foreach (addr_list[i]) csr_request(`OP_WR, addr_list[i], $urandom(), 0, 32'h0);
        foreach (addr_list[i]) csr_request(`OP_WR, addr_list[i], $urandom(), 0, '1);
        check_all();
        csr_request(`OP_RD, 14'h003, 0, 0, '1);
        csr_request(`OP_RD, 14'h2abc, 0, 0, '1);

        foreach (addr_list[i]) csr_request(`OP_XCHG, addr_list[i], $urandom(), $urandom(), '1);
        check_all();
        csr_request(`OP_WR, `CSR_BADV, 32'h8000_1234, 0, '1);
        csr_request(`OP_RD, `CSR_PGD, 0, 0, '1);
        csr_request(`OP_WR, `CSR_BADV, 32'h0000_1234, 0, '1);
        csr_request(`OP_RD, `CSR_PGD, 0, 0, '1);

        csr_request(`OP_WR, `CSR_EENTRY, 32'h1c00_8000, 0, '1);
        csr_request(`OP_WR, `CSR_TLBRENTRY, 32'h1c00_f000, 0, '1);
        csr_request(`OP_WR, `CSR_CRMD, 32'h0000_0017, 0, '1);   // plv 3, ie, paged
        start_cycle();
        raise_excp(6'h08, 9'h001, 32'h1c00_0104, 1'b0, 32'hdead_beef);
        check_all();
        start_cycle();
        take_ertn();
        check_all();
        start_cycle();
        raise_excp(`ECODE_TLBR, 9'h000, 32'h1c00_0220, 1'b1, 32'h7fff_e010);
        check_all();
        start_cycle();
        take_ertn();
        check_all();

        // exception against an instruction write of prmd
        start_cycle();
        set_inst(`OP_WR, `CSR_PRMD, 32'h0000_0005, 0, '1, 1'b0);
        raise_excp(6'h0b, 9'h000, 32'h1c00_0300, 1'b0, 32'h0);
        // tlb write against an instruction write of tlbehi
        start_cycle();
        set_inst(`OP_WR, `CSR_TLBEHI, 32'h1234_5678, 0, '1, 1'b0);
        load_tlb($urandom(), $urandom(), $urandom(), $urandom(), $urandom());
        check_all();

        start_cycle();
        @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #(num_requests * 10 * 4);
        $display("watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- design/csr_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_access
    import csr_pkg::*;
(
    input  wire csr_op_t op,
    input  wire u32_t    wr_data,
    input  wire u32_t    wr_mask,
    input  wire u32_t    old_data,
    output logic         csr_we,
    output u32_t         csr_wdata,
    output u32_t         rd_data
);

    u32_t merged;

    // mask bit 1 takes the new bit, 0 keeps the old one
    assign merged = (wr_data & wr_mask) | (old_data & ~wr_mask);

    always_comb begin
        case (op)
            `OP_WR: begin
                csr_we    = 1'b1;
                csr_wdata = wr_data;
            end
            `OP_XCHG: begin
                csr_we    = 1'b1;
                csr_wdata = merged;
            end
            default: begin              // rd and none leave the register alone
                csr_we    = 1'b0;
                csr_wdata = wr_data;
            end
        endcase
    end

    // every csr instruction hands back the value before the write
    assign rd_data = (op == `OP_NONE) ? '0 : old_data;

endmodule

`default_nettype wire

//--- design/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// csr numbers
`define CSR_CRMD      14'h000
`define CSR_PRMD      14'h001
`define CSR_EUEN      14'h002
`define CSR_ECFG      14'h004
`define CSR_ESTAT     14'h005
`define CSR_ERA       14'h006
`define CSR_BADV      14'h007
`define CSR_EENTRY    14'h00c
`define CSR_TLBIDX    14'h010
`define CSR_TLBEHI    14'h011
`define CSR_TLBELO0   14'h012
`define CSR_TLBELO1   14'h013
`define CSR_ASID      14'h018
`define CSR_PGDL      14'h019
`define CSR_PGDH      14'h01a
`define CSR_PGD       14'h01b
`define CSR_CPUID     14'h020
`define CSR_SAVE0     14'h030
`define CSR_SAVE1     14'h031
`define CSR_SAVE2     14'h032
`define CSR_SAVE3     14'h033
`define CSR_TLBRENTRY 14'h088
`define CSR_DMW0      14'h180
`define CSR_DMW1      14'h181

`define OP_NONE 2'd0
`define OP_RD   2'd1
`define OP_WR   2'd2
`define OP_XCHG 2'd3     // masked exchange

`define TLB_IDX_WID 4
`define PALEN       32
`define ASID_WID    10
`define ECODE_TLBR  6'h3f

`endif

//--- design/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // data word
    typedef logic [31:0] u32_t;

    // csr number as carried by the instruction
    typedef logic [13:0] csr_addr_t;

    typedef logic [1:0] plv_t;      // privilege level
    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

    // takes the OP_* values
    typedef logic [1:0] csr_op_t;

endpackage

`default_nettype wire

//--- design/csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_regfile
    import csr_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire csr_addr_t csr_addr,
    input  wire logic      csr_we,
    input  wire u32_t      csr_wdata,
    output u32_t           rd_value,
    input  wire logic      excp_we,
    input  wire plv_t      excp_pplv,
    input  wire logic      excp_pie,
    input  wire ecode_t    excp_ecode,
    input  wire esubcode_t excp_esubcode,
    input  wire u32_t      excp_era,
    input  wire u32_t      excp_badv,
    input  wire logic      excp_tlbr,
    input  wire logic      tlb_we,
    input  wire u32_t      tlb_tlbidx,
    input  wire u32_t      tlb_tlbehi,
    input  wire u32_t      tlb_tlbelo0,
    input  wire u32_t      tlb_tlbelo1,
    input  wire u32_t      tlb_asid,
    input  wire logic      ertn,
    output plv_t           crmd_plv,
    output logic           crmd_ie,
    output u32_t           eentry,
    output u32_t           tlbrentry,
    output u32_t           era,
    output u32_t           badv
);

    // bits outside these masks are reserved and stay zero
    localparam u32_t crmd_wmask   = 32'h0000_01ff;
    localparam u32_t prmd_wmask   = 32'h0000_0007;
    localparam u32_t euen_wmask   = 32'h0000_0001;
    localparam u32_t ecfg_wmask   = 32'h0000_1fff;
    localparam u32_t estat_wmask  = 32'h0000_0003;    // swi only
    localparam u32_t entry_wmask  = 32'hffff_ffc0;    // eentry and tlbrentry
    localparam u32_t tlbidx_wmask = 32'hbf00_0000 | ~(32'hffff_ffff << `TLB_IDX_WID);
    localparam u32_t tlbehi_wmask = 32'hffff_e000;
    localparam u32_t tlbelo_wmask = (32'hffff_ffff >> (36 - `PALEN)) & 32'hffff_ff7f;
    localparam u32_t asid_wmask   = ~(32'hffff_ffff << `ASID_WID);
    localparam u32_t pgd_wmask    = 32'hffff_f000;
    localparam u32_t dmw_wmask    = 32'hee00_0039;

    u32_t crmd_q, prmd_q, euen_q, ecfg_q, estat_q;
    u32_t era_q, badv_q, eentry_q, tlbrentry_q;
    u32_t tlbidx_q, tlbehi_q, tlbelo0_q, tlbelo1_q, asid_q;
    u32_t pgdl_q, pgdh_q, dmw0_q, dmw1_q;
    u32_t save_q [0:3];
    u32_t pgd_value;
    logic inst_we;
    logic ertn_we;

    // exception beats tlb beats instruction beats ertn
    assign inst_we = csr_we & ~excp_we & ~tlb_we;
    assign ertn_we = ertn & ~excp_we & ~tlb_we & ~csr_we;

    // mode and enable state is cleared by reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd_q  <= 32'h0000_0008;   // da = 1
            euen_q  <= '0;
            ecfg_q  <= '0;
            estat_q <= '0;
            dmw0_q  <= '0;
            dmw1_q  <= '0;
        end else if (excp_we) begin
            // refill runs in direct mode
            crmd_q[4:0]    <= {~excp_tlbr, excp_tlbr, 1'b0, 2'b00};  // {pg, da, ie, plv}
            estat_q[30:16] <= {excp_esubcode, excp_ecode};
        end else if (inst_we) begin
            case (csr_addr)
                `CSR_CRMD:  crmd_q  <= csr_wdata & crmd_wmask;
                `CSR_EUEN:  euen_q  <= csr_wdata & euen_wmask;
                `CSR_ECFG:  ecfg_q  <= csr_wdata & ecfg_wmask;
                `CSR_ESTAT: estat_q[1:0] <= csr_wdata[1:0] & estat_wmask[1:0];
                `CSR_DMW0:  dmw0_q  <= csr_wdata & dmw_wmask;
                `CSR_DMW1:  dmw1_q  <= csr_wdata & dmw_wmask;
                default: ;
            endcase
        end else if (ertn_we) begin
            crmd_q[2:0] <= prmd_q[2:0];     // back to saved plv and ie
        end
    end

    // context and translation registers
    always_ff @(posedge clk) begin
        if (excp_we) begin
            prmd_q <= {29'b0, excp_pie, excp_pplv};
            era_q  <= excp_era;
            badv_q <= excp_badv;
        end else if (tlb_we) begin
            tlbidx_q  <= tlb_tlbidx & tlbidx_wmask;
            tlbehi_q  <= tlb_tlbehi & tlbehi_wmask;
            tlbelo0_q <= tlb_tlbelo0 & tlbelo_wmask;
            tlbelo1_q <= tlb_tlbelo1 & tlbelo_wmask;
            asid_q    <= tlb_asid & asid_wmask;
        end else if (inst_we) begin
            case (csr_addr)
                `CSR_PRMD:      prmd_q      <= csr_wdata & prmd_wmask;
                `CSR_ERA:       era_q       <= csr_wdata;
                `CSR_BADV:      badv_q      <= csr_wdata;
                `CSR_EENTRY:    eentry_q    <= csr_wdata & entry_wmask;
                `CSR_TLBIDX:    tlbidx_q    <= csr_wdata & tlbidx_wmask;
                `CSR_TLBEHI:    tlbehi_q    <= csr_wdata & tlbehi_wmask;
                `CSR_TLBELO0:   tlbelo0_q   <= csr_wdata & tlbelo_wmask;
                `CSR_TLBELO1:   tlbelo1_q   <= csr_wdata & tlbelo_wmask;
                `CSR_ASID:      asid_q      <= csr_wdata & asid_wmask;
                `CSR_PGDL:      pgdl_q      <= csr_wdata & pgd_wmask;
                `CSR_PGDH:      pgdh_q      <= csr_wdata & pgd_wmask;
                `CSR_SAVE0:     save_q[0]   <= csr_wdata;
                `CSR_SAVE1:     save_q[1]   <= csr_wdata;
                `CSR_SAVE2:     save_q[2]   <= csr_wdata;
                `CSR_SAVE3:     save_q[3]   <= csr_wdata;
                `CSR_TLBRENTRY: tlbrentry_q <= csr_wdata & entry_wmask;
                default: ;
            endcase
        end
    end

    // upper half of the address space walks from pgdh
    assign pgd_value = badv_q[31] ? pgdh_q : pgdl_q;

    always_comb begin
        case (csr_addr)
            `CSR_CRMD:      rd_value = crmd_q;
            `CSR_PRMD:      rd_value = prmd_q;
            `CSR_EUEN:      rd_value = euen_q;
            `CSR_ECFG:      rd_value = ecfg_q;
            `CSR_ESTAT:     rd_value = estat_q;
            `CSR_ERA:       rd_value = era_q;
            `CSR_BADV:      rd_value = badv_q;
            `CSR_EENTRY:    rd_value = eentry_q;
            `CSR_TLBIDX:    rd_value = tlbidx_q;
            `CSR_TLBEHI:    rd_value = tlbehi_q;
            `CSR_TLBELO0:   rd_value = tlbelo0_q;
            `CSR_TLBELO1:   rd_value = tlbelo1_q;
            `CSR_ASID:      rd_value = (asid_q & asid_wmask) | (u32_t'(`ASID_WID) << 16);
            `CSR_PGDL:      rd_value = pgdl_q;
            `CSR_PGDH:      rd_value = pgdh_q;
            `CSR_PGD:       rd_value = pgd_value;
            `CSR_CPUID:     rd_value = '0;     // single core
            `CSR_SAVE0:     rd_value = save_q[0];
            `CSR_SAVE1:     rd_value = save_q[1];
            `CSR_SAVE2:     rd_value = save_q[2];
            `CSR_SAVE3:     rd_value = save_q[3];
            `CSR_TLBRENTRY: rd_value = tlbrentry_q;
            `CSR_DMW0:      rd_value = dmw0_q;
            `CSR_DMW1:      rd_value = dmw1_q;
            default:        rd_value = '0;
        endcase
    end

    assign crmd_plv  = crmd_q[1:0];
    assign crmd_ie   = crmd_q[2];
    assign eentry    = eentry_q;
    assign tlbrentry = tlbrentry_q;
    assign era       = era_q;
    assign badv      = badv_q;

endmodule

`default_nettype wire

//--- design/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import csr_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire csr_op_t   op,
    input  wire csr_addr_t addr,
    input  wire u32_t      wr_data,
    input  wire u32_t      wr_mask,
    output u32_t           rd_data,
    input  wire logic      excp_valid,
    input  wire ecode_t    excp_ecode,
    input  wire esubcode_t excp_esubcode,
    input  wire u32_t      excp_pc,
    input  wire logic      badv_we,
    input  wire u32_t      excp_badv,
    input  wire logic      ertn,
    input  wire logic      tlb_we,
    input  wire u32_t      tlb_tlbidx,
    input  wire u32_t      tlb_tlbehi,
    input  wire u32_t      tlb_tlbelo0,
    input  wire u32_t      tlb_tlbelo1,
    input  wire u32_t      tlb_asid,
    output logic           redirect_valid,
    output u32_t           redirect_pc
);

    u32_t old_data, csr_wdata, eentry, tlbrentry, era, badv;
    u32_t excp_era, excp_badv_new;
    logic csr_we, excp_we, excp_pie, excp_tlbr, crmd_ie;
    plv_t excp_pplv, crmd_plv;

    csr_access i_access (
        .op(op), .wr_data(wr_data), .wr_mask(wr_mask), .old_data(old_data),
        .csr_we(csr_we), .csr_wdata(csr_wdata), .rd_data(rd_data)
    );

    excp_commit i_excp (
        .excp_valid(excp_valid), .excp_ecode(excp_ecode), .excp_pc(excp_pc),
        .badv_we(badv_we), .excp_badv(excp_badv), .ertn(ertn),
        .crmd_plv(crmd_plv), .crmd_ie(crmd_ie), .eentry(eentry),
        .tlbrentry(tlbrentry), .era(era), .badv_old(badv),
        .excp_we(excp_we), .excp_pplv(excp_pplv), .excp_pie(excp_pie),
        .excp_era(excp_era), .excp_badv_new(excp_badv_new), .excp_tlbr(excp_tlbr),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    csr_regfile i_regfile (
        .clk(clk), .rst_n(rst_n), .csr_addr(addr), .csr_we(csr_we),
        .csr_wdata(csr_wdata), .rd_value(old_data), .excp_we(excp_we),
        .excp_pplv(excp_pplv), .excp_pie(excp_pie), .excp_ecode(excp_ecode),
        .excp_esubcode(excp_esubcode), .excp_era(excp_era), .excp_badv(excp_badv_new),
        .excp_tlbr(excp_tlbr), .tlb_we(tlb_we), .tlb_tlbidx(tlb_tlbidx),
        .tlb_tlbehi(tlb_tlbehi), .tlb_tlbelo0(tlb_tlbelo0), .tlb_tlbelo1(tlb_tlbelo1),
        .tlb_asid(tlb_asid), .ertn(ertn), .crmd_plv(crmd_plv), .crmd_ie(crmd_ie),
        .eentry(eentry), .tlbrentry(tlbrentry), .era(era), .badv(badv)
    );

endmodule

`default_nettype wire

//--- design/excp_commit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module excp_commit
    import csr_pkg::*;
(
    input  wire logic   excp_valid,
    input  wire ecode_t excp_ecode,
    input  wire u32_t   excp_pc,
    input  wire logic   badv_we,
    input  wire u32_t   excp_badv,
    input  wire logic   ertn,
    input  wire plv_t   crmd_plv,
    input  wire logic   crmd_ie,
    input  wire u32_t   eentry,
    input  wire u32_t   tlbrentry,
    input  wire u32_t   era,
    input  wire u32_t   badv_old,
    output logic        excp_we,
    output plv_t        excp_pplv,
    output logic        excp_pie,
    output u32_t        excp_era,
    output u32_t        excp_badv_new,
    output logic        excp_tlbr,
    output logic        redirect_valid,
    output u32_t        redirect_pc
);

    logic is_refill;

    assign is_refill = (excp_ecode == `ECODE_TLBR);

    // trap entry write set
    assign excp_we       = excp_valid;
    assign excp_pplv     = crmd_plv;            // saved into prmd
    assign excp_pie      = crmd_ie;
    assign excp_era      = excp_pc;
    assign excp_badv_new = badv_we ? excp_badv : badv_old;   // badv only moves on address faults
    assign excp_tlbr     = is_refill;

    // an exception in the same cycle as ertn takes the redirect
    always_comb begin
        redirect_valid = excp_valid | ertn;
        if (excp_valid) begin
            redirect_pc = is_refill ? tlbrentry : eentry;
        end else if (ertn) begin
            redirect_pc = era;
        end else begin
            redirect_pc = '0;
        end
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/csr_pkg.sv
design/csr_access.sv
design/excp_commit.sv
design/csr_regfile.sv
design/csr_unit.sv
bench/csr_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module csr_unit_tb -Mdir obj_dir &&
./obj_dir/Vcsr_unit_tb || { echo "simulation failed"; exit 1; }
